// File: vlog.f
simd_pkg.sv
vred.sv
vaddsub.sv
simd_ctrl.sv
simd_unit.sv
tb_simd_unit.sv

// File: run.sh
#!/bin/sh
# build the SIMD unit testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_simd_unit \
  -o sim_simd_unit > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_simd_unit > sim.log 2>&1

grep -q "^PASS: all tests$" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: tb_simd_unit.sv
/*
 * tb_simd_unit is the directed testbench for the 128-bit SIMD integer unit
 * with reference model, compare tasks and one task per behavior
 */

module tb_simd_unit;

  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD    = 20ns;  // 40 ns clock
  localparam int  RESET_CYCLES   = 4;
  localparam int  TIMEOUT_CYCLES = 16;    // per wait on valid_o
  localparam int  STREAM_LEN     = 12;

  logic                clk_i;
  logic                rstn_i;
  logic                valid_i;
  simd_pkg::simd_op_t  op_i;
  simd_pkg::sew_t      sew_i;
  simd_pkg::bus_simd_t vs1_i;
  simd_pkg::bus_simd_t vs2_i;
  logic                valid_o;
  logic                illegal_o;
  simd_pkg::bus_simd_t vd_o;

  integer              seed = 32'h69e7;
  int                  errors = 0;
  int                  timeouts = 0;
  simd_pkg::bus_simd_t exp_vd_q [$];  // expected results in issue order
  logic                exp_ill_q [$];

  simd_unit dut0 (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (valid_i),
    .op_i      (op_i),
    .sew_i     (sew_i),
    .vs1_i     (vs1_i),
    .vs2_i     (vs2_i),
    .valid_o   (valid_o),
    .illegal_o (illegal_o),
    .vd_o      (vd_o)
  );

  always #HALF_PERIOD clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // element-wise wrap or reduction with the carry kept
  function automatic simd_pkg::bus_simd_t ref_vd(input simd_pkg::simd_op_t op,
      input simd_pkg::sew_t sew, input simd_pkg::bus_simd_t vs1,
      input simd_pkg::bus_simd_t vs2);
    int          w;
    int          n;
    logic [127:0] mask;
    logic [127:0] a;
    logic [127:0] b;
    logic [127:0] res;
    w    = 8 << sew;                 // element width in bits
    n    = simd_pkg::SIMD_W / w;     // elements per vector
    mask = (128'd1 << w) - 128'd1;
    res  = '0;
    for (int e = 0; e < n; e++) begin
      a = (vs1 >> (e * w)) & mask;
      b = (vs2 >> (e * w)) & mask;
      case (op)
        simd_pkg::OP_VADD:    res = res | (((a + b) & mask) << (e * w));
        simd_pkg::OP_VSUB:    res = res | (((a - b) & mask) << (e * w));
        simd_pkg::OP_VREDSUM: res = res + a;  // full 128-bit accumulator
        default:              res = '0;       // unused encoding
      endcase
    end
    return res;
  endfunction

  function automatic logic ref_illegal(input simd_pkg::simd_op_t op);
    return !(op inside {simd_pkg::OP_VADD, simd_pkg::OP_VSUB, simd_pkg::OP_VREDSUM});
  endfunction

  function automatic simd_pkg::bus_simd_t rand_bus();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_bus(input string name, input simd_pkg::bus_simd_t exp,
      input simd_pkg::bus_simd_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive and collect on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic issue_op(input simd_pkg::simd_op_t op, input simd_pkg::sew_t sew,
      input simd_pkg::bus_simd_t vs1, input simd_pkg::bus_simd_t vs2);
    valid_i = 1'b1;
    op_i    = op;
    sew_i   = sew;
    vs1_i   = vs1;
    vs2_i   = vs2;
    exp_vd_q.push_back(ref_vd(op, sew, vs1, vs2));
    exp_ill_q.push_back(ref_illegal(op));
  endtask

  // counts falling edges until valid_o or the timeout
  task automatic wait_valid(output int cycles, output bit got);
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
      got = (valid_o === 1'b1);
    end
  endtask

  task automatic collect_result();
    int                  cycles;
    bit                  got;
    simd_pkg::bus_simd_t exp_vd;
    logic                exp_ill;
    exp_vd  = exp_vd_q.pop_front();
    exp_ill = exp_ill_q.pop_front();
    wait_valid(cycles, got);
    if (!got) begin
      timeouts++;
      $display("valid_o did not rise within %0d cycles of an operation", TIMEOUT_CYCLES);
    end else begin
      if (cycles != 1) begin
        errors++;
        $display("result came %0d cycles after its operation instead of 1", cycles);
      end
      check_flag("illegal_o", exp_ill, illegal_o);
      check_bus("vd_o", exp_vd, vd_o);
    end
  endtask

  // one idle cycle where the outputs drop back
  task automatic idle_check();
    valid_i = 1'b0;
    @(negedge clk_i);
    check_flag("valid_o", 1'b0, valid_o);
    check_flag("illegal_o", 1'b0, illegal_o);
  endtask

  task automatic run_op(input simd_pkg::simd_op_t op, input simd_pkg::sew_t sew,
      input simd_pkg::bus_simd_t vs1, input simd_pkg::bus_simd_t vs2);
    issue_op(op, sew, vs1, vs2);
    collect_result();
    idle_check();
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  // an illegal op held on the inputs must not come out while in reset
  task automatic reset_state();
    rstn_i  = 1'b0;
    valid_i = 1'b1;
    op_i    = simd_pkg::simd_op_t'(2'b11);
    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      check_flag("valid_o", 1'b0, valid_o);
      check_flag("illegal_o", 1'b0, illegal_o);
    end
    rstn_i  = 1'b1;
    valid_i = 1'b0;
    op_i    = simd_pkg::OP_VADD;
    @(negedge clk_i);  // first cycle out of reset
    check_flag("valid_o", 1'b0, valid_o);
    check_flag("illegal_o", 1'b0, illegal_o);
  endtask

  task automatic elementwise_add();
    simd_pkg::sew_t sew;
    for (int i = 0; i < 4; i++) begin
      sew = simd_pkg::sew_t'(i[1:0]);
      repeat (3) run_op(simd_pkg::OP_VADD, sew, rand_bus(), rand_bus());
      run_op(simd_pkg::OP_VADD, sew, '1, '1);              // carry in every lane
      run_op(simd_pkg::OP_VADD, sew, '1, {16{8'h01}});     // ripple up to each top
    end
  endtask

  task automatic elementwise_sub();
    simd_pkg::sew_t sew;
    for (int i = 0; i < 4; i++) begin
      sew = simd_pkg::sew_t'(i[1:0]);
      repeat (3) run_op(simd_pkg::OP_VSUB, sew, rand_bus(), rand_bus());
      run_op(simd_pkg::OP_VSUB, sew, '0, rand_bus());      // vs2 > vs1
      run_op(simd_pkg::OP_VSUB, sew, {16{8'h01}}, '1);
    end
  endtask

  task automatic reduction_sum();
    simd_pkg::sew_t sew;
    for (int i = 0; i < 4; i++) begin
      sew = simd_pkg::sew_t'(i[1:0]);
      repeat (3) run_op(simd_pkg::OP_VREDSUM, sew, rand_bus(), rand_bus());
      run_op(simd_pkg::OP_VREDSUM, sew, '1, '0);  // max total with 65 bits at sew 64
    end
  endtask

  // one op per cycle with each result checked on its own edge
  task automatic back_to_back();
    simd_pkg::simd_op_t op;
    simd_pkg::sew_t     sew;
    for (int k = 0; k < STREAM_LEN; k++) begin
      op  = simd_pkg::simd_op_t'(2'($unsigned($random(seed)) % 3));
      sew = simd_pkg::sew_t'(2'($random(seed)));
      if (k > 0) begin
        collect_result();  // previous op on the same edge as the next issue
      end
      issue_op(op, sew, rand_bus(), rand_bus());
    end
    collect_result();
    idle_check();
  endtask

  task automatic illegal_op();
    issue_op(simd_pkg::simd_op_t'(2'b11), simd_pkg::SEW_32, rand_bus(), rand_bus());
    collect_result();
    issue_op(simd_pkg::OP_VADD, simd_pkg::SEW_16, rand_bus(), rand_bus());  // right behind
    collect_result();
    idle_check();
  endtask

  initial begin
    clk_i   = 1'b0;
    rstn_i  = 1'b0;
    valid_i = 1'b0;
    op_i    = simd_pkg::OP_VADD;
    sew_i   = simd_pkg::SEW_8;
    vs1_i   = '0;
    vs2_i   = '0;
    reset_state();
    elementwise_add();
    elementwise_sub();
    reduction_sum();
    back_to_back();
    illegal_op();
    $display("tb_simd_unit: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: simd_unit.sv
/*
 * simd_unit: top of the 128-bit SIMD integer unit
 * control block plus add/sub and reduction datapaths, one-cycle latency
 */

module simd_unit (
  input  logic                clk_i,      // clock
  input  logic                rstn_i,     // async reset, active low
  input  logic                valid_i,    // op strobe
  input  simd_pkg::simd_op_t  op_i,       // operation
  input  simd_pkg::sew_t      sew_i,      // element width
  input  simd_pkg::bus_simd_t vs1_i,      // source vector 1
  input  simd_pkg::bus_simd_t vs2_i,      // source vector 2
  output logic                valid_o,    // result valid, one clock after valid_i
  output logic                illegal_o,  // unused op encoding
  output simd_pkg::bus_simd_t vd_o        // result
);

  logic                sub;      // decoded subtract select
  simd_pkg::bus_simd_t add_res;  // element-wise result
  simd_pkg::bus_simd_t red_res;  // reduction result

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  simd_ctrl ctrl0 (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (valid_i),
    .op_i      (op_i),
    .sub_o     (sub),
    .add_res_i (add_res),
    .red_res_i (red_res),
    .valid_o   (valid_o),
    .illegal_o (illegal_o),
    .vd_o      (vd_o)
  );

  //////////////////////////////////////////////////////////////////////
  // datapaths, both fed every cycle
  //////////////////////////////////////////////////////////////////////

  vaddsub addsub0 (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .sew_i         (sew_i),
    .sub_i         (sub),
    .data_vs1_i    (vs1_i),
    .data_vs2_i    (vs2_i),
    .add_data_vd_o (add_res)
  );

  vred red0 (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .sew_i         (sew_i),
    .data_vs_i     (vs1_i),   // reduction reads vs1 only
    .red_data_vd_o (red_res)
  );

endmodule

// File: simd_ctrl.sv
/*
 * simd_ctrl decodes the op, pipes valid and op one stage, flags illegal ops
 * and selects the result of the add/sub or the reduction datapath
 */

module simd_ctrl (
  input  logic                clk_i,      // clock
  input  logic                rstn_i,     // async active-low reset
  input  logic                valid_i,    // one strobe per op
  input  simd_pkg::simd_op_t  op_i,       // operation
  output logic                sub_o,      // subtract select to vaddsub
  input  simd_pkg::bus_simd_t add_res_i,  // vaddsub stage 1 result
  input  simd_pkg::bus_simd_t red_res_i,  // vred stage 1 result
  output logic                valid_o,    // result valid
  output logic                illegal_o,  // unused op encoding
  output simd_pkg::bus_simd_t vd_o        // selected result
);

  logic               valid_1;
  simd_pkg::simd_op_t op_1;

  assign sub_o = (op_i == simd_pkg::OP_VSUB);

  //////////////////////////////////////////////////////////////////////
  // valid / op pipe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      valid_1 <= 1'b0;
      op_1    <= simd_pkg::OP_VADD;
    end else begin
      valid_1 <= valid_i;
      if (valid_i) begin
        op_1 <= op_i;  // hold last op while idle
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////////////////////////

  assign valid_o = valid_1;

  always_comb begin
    illegal_o = 1'b0;
    vd_o      = '0;  // zero when idle or illegal
    if (valid_1) begin
      case (op_1)
        simd_pkg::OP_VADD,
        simd_pkg::OP_VSUB:    vd_o = add_res_i;
        simd_pkg::OP_VREDSUM: vd_o = red_res_i;
        default:              illegal_o = 1'b1;
      endcase
    end
  end

  // decode would misroute on an unknown op
  a_op_known : assert property (@(posedge clk_i) disable iff (!rstn_i)
    valid_i |-> !$isunknown(op_i));

  // illegal only alongside the result of an op issued with the unused encoding
  a_illegal_valid : assert property (@(posedge clk_i) disable iff (!rstn_i)
    illegal_o |-> valid_o && $past(op_i) == simd_pkg::simd_op_t'(2'b11));

endmodule

// File: vaddsub.sv
/*
 * vaddsub: element-wise add / subtract over two 128-bit vectors
 * sixteen 8-bit lanes, carries chained only inside an element
 */

module vaddsub (
  input  logic                clk_i,          // clock
  input  logic                rstn_i,         // async reset, active low
  input  simd_pkg::sew_t      sew_i,          // element width
  input  logic                sub_i,          // 1: vs1 - vs2
  input  simd_pkg::bus_simd_t data_vs1_i,     // source vector 1
  input  simd_pkg::bus_simd_t data_vs2_i,     // source vector 2
  output simd_pkg::bus_simd_t add_data_vd_o   // per-element result
);

  //////////////////////////////////////////////////////////////////////
  // stage 0 -> stage 1
  //////////////////////////////////////////////////////////////////////

  simd_pkg::sew_t      sew_1;
  logic                sub_1;
  simd_pkg::bus_simd_t data_vs1_1;
  simd_pkg::bus_simd_t data_vs2_1;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      sew_1 <= simd_pkg::SEW_8;
      sub_1 <= 1'b0;
    end else begin
      sew_1 <= sew_i;
      sub_1 <= sub_i;
    end
  end

  always_ff @(posedge clk_i) begin
    data_vs1_1 <= data_vs1_i;
    data_vs2_1 <= data_vs2_i;
  end

  //////////////////////////////////////////////////////////////////////
  // stage 1, segmented lanes
  //////////////////////////////////////////////////////////////////////

  simd_pkg::bus_simd_t opb;        // vs2, inverted for subtract
  logic [3:0]          lane_mask;  // low lane-index bits inside one element

  assign opb = sub_1 ? ~data_vs2_1 : data_vs2_1;

  // lanes per element is 1 << sew, mask is that minus one
  assign lane_mask = 4'((4'd1 << sew_1) - 4'd1);

  always_comb begin
    logic [8:0] lane_sum;
    logic       carry;
    carry         = 1'b0;
    add_data_vd_o = '0;
    for (int i = 0; i < simd_pkg::NUM_LANES; i++) begin
      // first lane of an element: restart the chain
      // cin = 1 completes the two's complement on subtract
      if ((4'(i) & lane_mask) == 4'd0) begin
        carry = sub_1;
      end
      lane_sum = {1'b0, data_vs1_1[8*i +: 8]} + {1'b0, opb[8*i +: 8]} + {8'd0, carry};
      add_data_vd_o[8*i +: 8] = lane_sum[7:0];
      carry = lane_sum[8];  // into the next lane, dropped at element top
    end
  end

endmodule

// File: vred.sv
/*
 * vred: reduction sum over one 128-bit source vector
 * input register stage, then a widening adder tree picked by sew
 */

module vred (
  input  logic                clk_i,          // clock
  input  logic                rstn_i,         // async reset, active low
  input  simd_pkg::sew_t      sew_i,          // element width
  input  simd_pkg::bus_simd_t data_vs_i,      // source vector
  output simd_pkg::bus_simd_t red_data_vd_o   // zero-extended sum
);

  //////////////////////////////////////////////////////////////////////
  // stage 0 -> stage 1
  //////////////////////////////////////////////////////////////////////

  simd_pkg::sew_t      sew_1;
  simd_pkg::bus_simd_t data_vs_1;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      sew_1 <= simd_pkg::SEW_8;
    end else begin
      sew_1 <= sew_i;
    end
  end

  always_ff @(posedge clk_i) begin
    data_vs_1 <= data_vs_i;  // payload, no reset
  end

  //////////////////////////////////////////////////////////////////////
  // stage 1, adder trees
  //////////////////////////////////////////////////////////////////////

  // each level one bit wider than the last, so no carry is lost
  logic [8:0]  s8_l1  [8];
  logic [9:0]  s8_l2  [4];
  logic [10:0] s8_l3  [2];
  logic [11:0] s8_sum;       // 16 x 8b
  logic [16:0] s16_l1 [4];
  logic [17:0] s16_l2 [2];
  logic [18:0] s16_sum;      // 8 x 16b
  logic [32:0] s32_l1 [2];
  logic [33:0] s32_sum;      // 4 x 32b
  logic [64:0] s64_sum;      // 2 x 64b, up to 65 bits

  always_comb begin
    // sew 8
    for (int i = 0; i < 8; i++) begin
      s8_l1[i] = {1'b0, data_vs_1[16*i +: 8]} + {1'b0, data_vs_1[16*i+8 +: 8]};
    end
    for (int i = 0; i < 4; i++) begin
      s8_l2[i] = {1'b0, s8_l1[2*i]} + {1'b0, s8_l1[2*i+1]};
    end
    for (int i = 0; i < 2; i++) begin
      s8_l3[i] = {1'b0, s8_l2[2*i]} + {1'b0, s8_l2[2*i+1]};
    end
    s8_sum = {1'b0, s8_l3[0]} + {1'b0, s8_l3[1]};

    // sew 16
    for (int i = 0; i < 4; i++) begin
      s16_l1[i] = {1'b0, data_vs_1[32*i +: 16]} + {1'b0, data_vs_1[32*i+16 +: 16]};
    end
    for (int i = 0; i < 2; i++) begin
      s16_l2[i] = {1'b0, s16_l1[2*i]} + {1'b0, s16_l1[2*i+1]};
    end
    s16_sum = {1'b0, s16_l2[0]} + {1'b0, s16_l2[1]};

    // sew 32
    for (int i = 0; i < 2; i++) begin
      s32_l1[i] = {1'b0, data_vs_1[64*i +: 32]} + {1'b0, data_vs_1[64*i+32 +: 32]};
    end
    s32_sum = {1'b0, s32_l1[0]} + {1'b0, s32_l1[1]};

    // sew 64
    s64_sum = {1'b0, data_vs_1[63:0]} + {1'b0, data_vs_1[127:64]};
  end

  // pick the tree, zero-extend to the bus
  always_comb begin
    case (sew_1)
      simd_pkg::SEW_8:  red_data_vd_o = {{(simd_pkg::SIMD_W-12){1'b0}}, s8_sum};
      simd_pkg::SEW_16: red_data_vd_o = {{(simd_pkg::SIMD_W-19){1'b0}}, s16_sum};
      simd_pkg::SEW_32: red_data_vd_o = {{(simd_pkg::SIMD_W-34){1'b0}}, s32_sum};
      simd_pkg::SEW_64: red_data_vd_o = {{(simd_pkg::SIMD_W-65){1'b0}}, s64_sum};
      default:          red_data_vd_o = '0;
    endcase
  end

  // registered width must stay known, else the tree select goes X
  a_sew_known : assert property (@(posedge clk_i) disable iff (!rstn_i)
    !$isunknown(sew_1));

endmodule

// File: simd_pkg.sv
/*
 * simd package: bus width, element width and operation encodings
 * shared by the 128-bit SIMD integer unit and its testbench
 */

package simd_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int SIMD_W    = 128;         // operand / result bus width
  localparam int NUM_LANES = SIMD_W / 8;  // 8-bit lanes in the add/sub datapath

  // one bus type for every operand and result
  typedef logic [SIMD_W-1:0] bus_simd_t;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // element width, also log2 of lanes per element
  typedef enum logic [1:0] {
    SEW_8  = 2'b00,
    SEW_16 = 2'b01,
    SEW_32 = 2'b10,
    SEW_64 = 2'b11
  } sew_t;

  // operation select
  // 2'b11 left unassigned, flagged illegal by the control block
  typedef enum logic [1:0] {
    OP_VADD    = 2'b00,  // element-wise add
    OP_VSUB    = 2'b01,  // element-wise vs1 - vs2
    OP_VREDSUM = 2'b10   // unsigned sum of vs1 elements
  } simd_op_t;

endpackage
